// ==== Bender.yml ====
package:
  name: vec_exec

sources:
  - files:
      - source/vec_pkg.sv
      - source/vec_pipe_reg.sv
      - source/vec_element_decode.sv
      - source/vec_lane_alu.sv
      - source/vec_tail_merge.sv
      - source/vec_exec_top.sv
  - target: test
    files:
      - test/vec_exec_tb.sv

// ==== source/vec_element_decode.sv ====
/*
 * Vector element decoder
 * Turns SEW, vl and vstart into the byte merge mask for the ALU
 * and the byte body mask for the tail stage
 */

`timescale 1ns/10ps

module vec_element_decode #(
    parameter int  DATA_BYTES = 8,
    localparam int VL_W       = $clog2(DATA_BYTES) + 1
) (
    input  vec_pkg::vsew_e         vsew,
    input  logic [VL_W-1:0]        vl,
    input  logic [VL_W-1:0]        vstart,
    output logic [DATA_BYTES-2:0]  merge,
    output logic [DATA_BYTES-1:0]  body
);

    // Widest SEW whose element still fits in the register
    localparam int REG_SEW_CODE = $clog2(DATA_BYTES);
    localparam int MAX_LEGAL    = (REG_SEW_CODE < vec_pkg::MAX_SEW_CODE) ?
                                  REG_SEW_CODE : vec_pkg::MAX_SEW_CODE;

    logic [2:0]                  eff_sew;
    logic [vec_pkg::NUM_SEW-1:0] sew_onehot;
    logic [VL_W-1:0]             elem_idx [DATA_BYTES];

    // Clamp reserved and oversize codes to the widest legal SEW
    always_comb begin
        if (vsew > MAX_LEGAL) begin
            eff_sew = 3'(MAX_LEGAL);
        end else begin
            eff_sew = vsew;
        end
    end

    // One-hot of the effective element size
    always_comb begin
        for (int k = 0; k < vec_pkg::NUM_SEW; k++) begin
            sew_onehot[k] = (eff_sew == 3'(k));
        end
    end

    // Merge bit i joins byte i with byte i+1
    // SEW_8 never merges, so only the wider sizes contribute
    always_comb begin
        merge = '0;
        for (int i = 0; i < DATA_BYTES - 1; i++) begin
            for (int k = 1; k < vec_pkg::NUM_SEW; k++) begin
                if (((i + 1) % (1 << k)) != 0) begin
                    merge[i] = merge[i] | sew_onehot[k];
                end
            end
        end
    end

    // Element index of each byte is the byte number shifted by log2 of the size
    always_comb begin
        for (int b = 0; b < DATA_BYTES; b++) begin
            elem_idx[b] = '0;
            for (int k = 0; k < vec_pkg::NUM_SEW; k++) begin
                if (sew_onehot[k]) begin
                    elem_idx[b] = VL_W'(b >> k);
                end
            end
        end
    end

    // Body is the window [vstart, vl)
    // Prestart and tail bytes fall outside and stay undisturbed downstream
    always_comb begin
        for (int b = 0; b < DATA_BYTES; b++) begin
            body[b] = (elem_idx[b] >= vstart) && (elem_idx[b] < vl);
        end
    end

endmodule

// ==== source/vec_exec_top.sv ====
/*
 * Vector execution slice top level
 * Three-stage pipe of input capture, element decode and ALU with tail merge
 */

`timescale 1ns/10ps

module vec_exec_top #(
    parameter int  DATA_BYTES = 8,
    localparam int VL_W       = $clog2(DATA_BYTES) + 1,
    localparam int DATA_W     = DATA_BYTES * vec_pkg::BYTE_W
) (
    input  logic              clk,
    input  logic              arst_n,
    input  logic              in_valid,
    input  vec_pkg::alu_op_e  op,
    input  vec_pkg::vsew_e    vsew,
    input  logic [VL_W-1:0]   vl,
    input  logic [VL_W-1:0]   vstart,
    input  logic [DATA_W-1:0] vs2,
    input  logic [DATA_W-1:0] vs1,
    input  logic [DATA_W-1:0] vd_old,
    output logic              out_valid,
    output logic [DATA_W-1:0] vd
);

    // Raw operation as it enters
    typedef struct packed {
        vec_pkg::alu_op_e  op;
        vec_pkg::vsew_e    vsew;
        logic [VL_W-1:0]   vl;
        logic [VL_W-1:0]   vstart;
        logic [DATA_W-1:0] vs2;
        logic [DATA_W-1:0] vs1;
        logic [DATA_W-1:0] vd_old;
    } stage_a_t;

    // Decoded masks plus operands for the ALU stage
    typedef struct packed {
        logic [DATA_BYTES-2:0] merge;
        logic [DATA_BYTES-1:0] body;
        vec_pkg::alu_op_e      op;
        logic [DATA_W-1:0]     vs2;
        logic [DATA_W-1:0]     vs1;
        logic [DATA_W-1:0]     vd_old;
    } stage_b_t;

    // Final destination value
    typedef logic [DATA_W-1:0] stage_c_t;

    stage_a_t              a_in;
    stage_a_t              a_out;
    logic                  a_valid;
    stage_b_t              b_in;
    stage_b_t              b_out;
    logic                  b_valid;
    stage_c_t              c_in;
    logic [DATA_BYTES-2:0] dec_merge;
    logic [DATA_BYTES-1:0] dec_body;
    logic [DATA_W-1:0]     alu_result;

    assign a_in = '{op: op, vsew: vsew, vl: vl, vstart: vstart,
                    vs2: vs2, vs1: vs1, vd_old: vd_old};

    vec_pipe_reg #(.payload_t(stage_a_t)) i_reg_a (
        .clk       (clk),
        .arst_n    (arst_n),
        .in_valid  (in_valid),
        .in_data   (a_in),
        .out_valid (a_valid),
        .out_data  (a_out)
    );

    vec_element_decode #(.DATA_BYTES(DATA_BYTES)) i_decode (
        .vsew   (a_out.vsew),
        .vl     (a_out.vl),
        .vstart (a_out.vstart),
        .merge  (dec_merge),
        .body   (dec_body)
    );

    assign b_in = '{merge: dec_merge, body: dec_body, op: a_out.op,
                    vs2: a_out.vs2, vs1: a_out.vs1, vd_old: a_out.vd_old};

    vec_pipe_reg #(.payload_t(stage_b_t)) i_reg_b (
        .clk       (clk),
        .arst_n    (arst_n),
        .in_valid  (a_valid),
        .in_data   (b_in),
        .out_valid (b_valid),
        .out_data  (b_out)
    );

    vec_lane_alu #(.DATA_BYTES(DATA_BYTES)) i_alu (
        .op     (b_out.op),
        .merge  (b_out.merge),
        .vs2    (b_out.vs2),
        .vs1    (b_out.vs1),
        .result (alu_result)
    );

    vec_tail_merge #(.DATA_BYTES(DATA_BYTES)) i_tail (
        .body   (b_out.body),
        .result (alu_result),
        .vd_old (b_out.vd_old),
        .vd     (c_in)
    );

    vec_pipe_reg #(.payload_t(stage_c_t)) i_reg_c (
        .clk       (clk),
        .arst_n    (arst_n),
        .in_valid  (b_valid),
        .in_data   (c_in),
        .out_valid (out_valid),
        .out_data  (vd)
    );

endmodule

// ==== source/vec_lane_alu.sv ====
/*
 * Byte-sliced vector ALU
 * One 8-bit adder per byte, carry chain cut at element boundaries by merge
 */

`timescale 1ns/10ps

module vec_lane_alu #(
    parameter int  DATA_BYTES = 8,
    localparam int DATA_W     = DATA_BYTES * vec_pkg::BYTE_W
) (
    input  vec_pkg::alu_op_e       op,
    input  logic [DATA_BYTES-2:0]  merge,
    input  logic [DATA_W-1:0]      vs2,
    input  logic [DATA_W-1:0]      vs1,
    output logic [DATA_W-1:0]      result
);

    localparam int BW = vec_pkg::BYTE_W;

    logic                  is_sub;
    logic [DATA_BYTES-1:0] carry_in;
    logic [DATA_BYTES-1:0] carry_out;

    assign is_sub = (op == vec_pkg::OP_SUB);

    for (genvar b = 0; b < DATA_BYTES; b++) begin : gen_byte
        logic [BW-1:0] opa;
        logic [BW-1:0] opb;
        logic [BW-1:0] sum;
        logic [BW-1:0] res_byte;

        assign opa = vs2[b*BW +: BW];

        // Subtract is vs2 + ~vs1 + 1 per element
        assign opb = is_sub ? ~vs1[b*BW +: BW] : vs1[b*BW +: BW];

        // Element start gets the injected carry, otherwise ripple from below
        if (b == 0) begin : gen_first
            assign carry_in[b] = is_sub;
        end else begin : gen_chain
            assign carry_in[b] = merge[b-1] ? carry_out[b-1] : is_sub;
        end

        assign {carry_out[b], sum} = {1'b0, opa} + {1'b0, opb} + {{BW{1'b0}}, carry_in[b]};

        // Logic ops work on raw operands and ignore the merge mask
        always_comb begin
            case (op)
                vec_pkg::OP_ADD,
                vec_pkg::OP_SUB: res_byte = sum;
                vec_pkg::OP_AND: res_byte = vs2[b*BW +: BW] & vs1[b*BW +: BW];
                vec_pkg::OP_OR:  res_byte = vs2[b*BW +: BW] | vs1[b*BW +: BW];
                vec_pkg::OP_XOR: res_byte = vs2[b*BW +: BW] ^ vs1[b*BW +: BW];
                default:         res_byte = '0;
            endcase
        end

        assign result[b*BW +: BW] = res_byte;
    end

endmodule

// ==== source/vec_pipe_reg.sv ====
/*
 * Vector pipeline register
 * Valid bit runs every cycle, payload only loads on a valid beat
 */

`timescale 1ns/10ps

module vec_pipe_reg #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     arst_n,
    input  logic     in_valid,
    input  payload_t in_data,
    output logic     out_valid,
    output payload_t out_data
);

    // Valid strobe follows the input one cycle later
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= in_valid;
        end
    end

    // Data flops hold still while the pipe is idle
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            out_data <= '0;
        end else if (in_valid) begin
            out_data <= in_data;
        end
    end

endmodule

// ==== source/vec_pkg.sv ====
/*
 * Vector execution slice shared definitions
 * SEW codes, ALU operation codes and sizing constants used by every stage
 */

package vec_pkg;

    // Bits per byte lane
    localparam int BYTE_W = 8;

    // Widest SEW code the slice supports (SEW_64)
    localparam int MAX_SEW_CODE = 3;

    // Number of legal SEW settings and of one-hot bits in the decoder
    localparam int NUM_SEW = MAX_SEW_CODE + 1;

    // vtype.vsew encoding
    // Codes 4 to 7 are reserved and get clamped by the decoder
    typedef enum logic [2:0] {
        SEW_8  = 3'd0,
        SEW_16 = 3'd1,
        SEW_32 = 3'd2,
        SEW_64 = 3'd3
    } vsew_e;

    // ALU operation select
    // Any code not listed yields an all-zero result
    typedef enum logic [2:0] {
        OP_ADD = 3'd0,
        OP_SUB = 3'd1,
        OP_AND = 3'd2,
        OP_OR  = 3'd3,
        OP_XOR = 3'd4
    } alu_op_e;

endpackage

// ==== source/vec_tail_merge.sv ====
/*
 * Vector tail merge
 * Writes ALU bytes inside the body, keeps old destination bytes elsewhere
 */

`timescale 1ns/10ps

module vec_tail_merge #(
    parameter int  DATA_BYTES = 8,
    localparam int DATA_W     = DATA_BYTES * vec_pkg::BYTE_W
) (
    input  logic [DATA_BYTES-1:0] body,
    input  logic [DATA_W-1:0]     result,
    input  logic [DATA_W-1:0]     vd_old,
    output logic [DATA_W-1:0]     vd
);

    localparam int BW = vec_pkg::BYTE_W;

    logic [DATA_W-1:0] write_mask;

    // Spread each body bit over its byte
    for (genvar b = 0; b < DATA_BYTES; b++) begin : gen_mask
        assign write_mask[b*BW +: BW] = {BW{body[b]}};
    end

    // Tail and prestart bytes are undisturbed
    assign vd = (result & write_mask) | (vd_old & ~write_mask);

endmodule

// ==== test/vec_exec_tb.sv ====
/*
 * Vector execution slice testbench
 * Directed tests with a per-element reference model and a result monitor
 */

`timescale 1ns/10ps

module vec_exec_tb;

    localparam int DATA_BYTES = 8;
    localparam int DATA_W     = DATA_BYTES * 8;
    localparam int VL_W       = $clog2(DATA_BYTES) + 1;
    localparam int WIDEST_SEW = ($clog2(DATA_BYTES) < vec_pkg::MAX_SEW_CODE) ?
                                $clog2(DATA_BYTES) : vec_pkg::MAX_SEW_CODE;
    localparam int TIMEOUT    = 50;

    logic              clk = 1'b0;
    logic              arst_n;
    logic              in_valid;
    vec_pkg::alu_op_e  op;
    vec_pkg::vsew_e    vsew;
    logic [VL_W-1:0]   vl;
    logic [VL_W-1:0]   vstart;
    logic [DATA_W-1:0] vs2;
    logic [DATA_W-1:0] vs1;
    logic [DATA_W-1:0] vd_old;
    logic              out_valid;
    logic [DATA_W-1:0] vd;

    integer            seed = 32'hc99b0158;
    int                cycle = 0;
    int                errors = 0;
    int                err_mark = 0;
    int                tests_run = 0;
    int                tests_failed = 0;
    int                sent = 0;
    int                received = 0;
    string             cur_test = "none";
    logic [DATA_W-1:0] exp_q [$];
    int                cyc_q [$];
    logic [DATA_W-1:0] mon_data;
    int                mon_cycle;

    vec_exec_top #(.DATA_BYTES(DATA_BYTES)) i_dut (
        .clk       (clk),
        .arst_n    (arst_n),
        .in_valid  (in_valid),
        .op        (op),
        .vsew      (vsew),
        .vl        (vl),
        .vstart    (vstart),
        .vs2       (vs2),
        .vs1       (vs1),
        .vd_old    (vd_old),
        .out_valid (out_valid),
        .vd        (vd)
    );

    always #50 clk = ~clk;

    always @(posedge clk) begin
        cycle <= cycle + 1;
    end

    task automatic check_data(input string name, input logic [DATA_W-1:0] expd,
                              input logic [DATA_W-1:0] act);
        if (act !== expd) begin
            $display("Error in %s: expected %h, got %h", name, expd, act);
            errors++;
        end
    endtask

    task automatic check_count(input string name, input int expd, input int act);
        if (act != expd) begin
            $display("Error in %s: expected %0d results, got %0d", name, expd, act);
            errors++;
        end
    endtask

    task automatic check_latency(input string name, input int expd, input int act);
        if (act != expd) begin
            $display("Error in %s: expected result at cycle %0d, got cycle %0d", name, expd, act);
            errors++;
        end
    endtask

    // Results are sampled on the falling edge between driving edges
    always @(negedge clk) begin
        if (arst_n && out_valid) begin
            if (exp_q.size() == 0) begin
                $display("%s: out_valid rose with no operation outstanding", cur_test);
                errors++;
            end else begin
                mon_data  = exp_q.pop_front();
                mon_cycle = cyc_q.pop_front();
                check_data(cur_test, mon_data, vd);
                check_latency(cur_test, mon_cycle, cycle);
            end
            received++;
        end
    end

    // Expected vd computed element by element on the element width
    function automatic logic [DATA_W-1:0] ref_vd(
        input vec_pkg::alu_op_e o, input logic [2:0] sew_code, input int vl_v, input int vs_v,
        input logic [DATA_W-1:0] a_reg, input logic [DATA_W-1:0] b_reg,
        input logic [DATA_W-1:0] old);
        int          eff;
        int          ebits;
        logic [63:0] emask;
        logic [63:0] a;
        logic [63:0] b;
        logic [63:0] r;
        logic [DATA_W-1:0] res;
        eff   = (sew_code > WIDEST_SEW) ? WIDEST_SEW : int'(sew_code);
        ebits = 8 << eff;
        emask = (ebits == 64) ? {64{1'b1}} : ((64'd1 << ebits) - 64'd1);
        res   = old;
        for (int e = 0; e < DATA_W / ebits; e++) begin
            a = 64'(a_reg >> (e * ebits)) & emask;
            b = 64'(b_reg >> (e * ebits)) & emask;
            case (o)
                vec_pkg::OP_ADD: r = a + b;
                vec_pkg::OP_SUB: r = a - b;
                vec_pkg::OP_AND: r = a & b;
                vec_pkg::OP_OR:  r = a | b;
                vec_pkg::OP_XOR: r = a ^ b;
                default:         r = '0;
            endcase
            r = r & emask;
            if (e >= vs_v && e < vl_v) begin
                res = (res & ~(DATA_W'(emask) << (e * ebits))) | (DATA_W'(r) << (e * ebits));
            end
        end
        return res;
    endfunction

    function automatic logic [DATA_W-1:0] rand_data();
        logic [DATA_W-1:0] d;
        for (int w = 0; w < DATA_W / 32; w++) begin
            d[w*32 +: 32] = $random(seed);
        end
        return d;
    endfunction

    // Result is due after the third edge from the one that drives it
    task automatic drive_op(input vec_pkg::alu_op_e o, input logic [2:0] sew_code,
                            input int vl_v, input int vs_v, input logic [DATA_W-1:0] a,
                            input logic [DATA_W-1:0] b, input logic [DATA_W-1:0] old,
                            input logic [DATA_W-1:0] expd);
        @(posedge clk);
        in_valid <= 1'b1;
        op       <= o;
        vsew     <= vec_pkg::vsew_e'(sew_code);
        vl       <= VL_W'(vl_v);
        vstart   <= VL_W'(vs_v);
        vs2      <= a;
        vs1      <= b;
        vd_old   <= old;
        exp_q.push_back(expd);
        cyc_q.push_back(cycle + 4);
        sent++;
    endtask

    task automatic begin_test(input string name);
        cur_test = name;
        err_mark = errors;
        sent     = 0;
        received = 0;
    endtask

    task automatic wait_results();
        int waited;
        waited = 0;
        while (exp_q.size() != 0 && waited < TIMEOUT) begin
            @(posedge clk);
            waited++;
        end
        if (exp_q.size() != 0) begin
            $display("%s: timed out, no result arrived for %0d operations", cur_test,
                     exp_q.size());
            errors++;
            exp_q.delete();
            cyc_q.delete();
        end
    endtask

    task automatic finish_test();
        @(posedge clk);
        in_valid <= 1'b0;
        wait_results();
        check_count(cur_test, sent, received);
        tests_run++;
        if (errors == err_mark) begin
            $display("PASS %s", cur_test);
        end else begin
            tests_failed++;
            $display("FAIL %s with %0d errors", cur_test, errors - err_mark);
        end
    endtask

    task automatic test_reset_idle();
        int pulses;
        begin_test("test_reset_idle");
        pulses = 0;
        for (int n = 0; n < 10; n++) begin
            @(negedge clk);
            if (out_valid !== 1'b0) begin
                pulses++;
            end
        end
        check_count(cur_test, 0, pulses);
        finish_test();
    endtask

    task automatic test_add_sub_all_sew();
        vec_pkg::alu_op_e  o;
        logic [DATA_W-1:0] a;
        logic [DATA_W-1:0] b;
        logic [DATA_W-1:0] old;
        int                full;
        begin_test("test_add_sub_all_sew");
        for (int s = 0; s <= WIDEST_SEW; s++) begin
            full = DATA_BYTES >> s;
            for (int n = 0; n < 8; n++) begin
                o   = n[0] ? vec_pkg::OP_SUB : vec_pkg::OP_ADD;
                // First two cases run a carry or borrow through every byte
                a   = (n == 0) ? '1 : (n == 1) ? '0 : rand_data();
                b   = (n < 2) ? {DATA_BYTES{8'h01}} : rand_data();
                old = rand_data();
                drive_op(o, 3'(s), full, 0, a, b, old, ref_vd(o, 3'(s), full, 0, a, b, old));
            end
        end
        finish_test();
    endtask

    task automatic test_logic_ops();
        vec_pkg::alu_op_e  o;
        logic [2:0]        s;
        logic [DATA_W-1:0] a;
        logic [DATA_W-1:0] b;
        logic [DATA_W-1:0] old;
        begin_test("test_logic_ops");
        for (int n = 0; n < 30; n++) begin
            o   = vec_pkg::alu_op_e'(3'(2 + n % 3));
            s   = 3'($unsigned($random(seed)) % (WIDEST_SEW + 1));
            a   = rand_data();
            b   = rand_data();
            old = rand_data();
            drive_op(o, s, DATA_BYTES, 0, a, b, old, ref_vd(o, s, DATA_BYTES, 0, a, b, old));
        end
        finish_test();
    endtask

    task automatic test_tail_prestart();
        logic [DATA_W-1:0] a;
        logic [DATA_W-1:0] b;
        logic [DATA_W-1:0] old;
        logic [DATA_W-1:0] expd;
        begin_test("test_tail_prestart");
        for (int s = 0; s <= WIDEST_SEW; s++) begin
            for (int l = 0; l <= DATA_BYTES; l++) begin
                for (int st = 0; st <= DATA_BYTES; st++) begin
                    a    = rand_data();
                    b    = rand_data();
                    old  = rand_data();
                    // Empty body leaves the old destination untouched
                    expd = (st >= l) ? old : ref_vd(vec_pkg::OP_ADD, 3'(s), l, st, a, b, old);
                    drive_op(vec_pkg::OP_ADD, 3'(s), l, st, a, b, old, expd);
                end
            end
        end
        finish_test();
    endtask

    task automatic test_back_to_back();
        vec_pkg::alu_op_e  o;
        logic [2:0]        s;
        int                l;
        logic [DATA_W-1:0] a;
        logic [DATA_W-1:0] b;
        logic [DATA_W-1:0] old;
        begin_test("test_back_to_back");
        for (int n = 0; n < 20; n++) begin
            o   = vec_pkg::alu_op_e'(3'($unsigned($random(seed)) % 5));
            s   = 3'($unsigned($random(seed)) % (WIDEST_SEW + 1));
            l   = $unsigned($random(seed)) % (DATA_BYTES + 1);
            a   = rand_data();
            b   = rand_data();
            old = rand_data();
            drive_op(o, s, l, 0, a, b, old, ref_vd(o, s, l, 0, a, b, old));
        end
        finish_test();
    endtask

    task automatic test_sew_clamp();
        vec_pkg::alu_op_e  o;
        logic [DATA_W-1:0] a;
        logic [DATA_W-1:0] b;
        logic [DATA_W-1:0] old;
        begin_test("test_sew_clamp");
        for (int code = 4; code < 8; code++) begin
            for (int n = 0; n < 5; n++) begin
                o   = vec_pkg::alu_op_e'(3'(n));
                a   = rand_data();
                b   = rand_data();
                old = rand_data();
                // Reserved code must behave as SEW_64
                drive_op(o, 3'(code), DATA_BYTES, 0, a, b, old,
                         ref_vd(o, 3'(vec_pkg::SEW_64), DATA_BYTES, 0, a, b, old));
            end
        end
        finish_test();
    endtask

    initial begin
        arst_n   <= 1'b0;
        in_valid <= 1'b0;
        op       <= vec_pkg::OP_ADD;
        vsew     <= vec_pkg::SEW_8;
        vl       <= '0;
        vstart   <= '0;
        vs2      <= '0;
        vs1      <= '0;
        vd_old   <= '0;
        repeat (2) @(posedge clk);
        arst_n <= 1'b1;

        test_reset_idle();
        test_add_sub_all_sew();
        test_logic_ops();
        test_tail_prestart();
        test_back_to_back();
        test_sew_clamp();

        $display("Tests run: %0d, failed: %0d, errors: %0d", tests_run, tests_failed, errors);
        if (errors == 0 && tests_failed == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

// ==== vec_exec_top.f ====
source/vec_pkg.sv
source/vec_pipe_reg.sv
source/vec_element_decode.sv
source/vec_lane_alu.sv
source/vec_tail_merge.sv
source/vec_exec_top.sv
test/vec_exec_tb.sv
